/* regex_cpu.f */
regex_pkg.sv
pc_stream_if.sv
issue_if.sv
regex_fetch.sv
regex_execute.sv
pc_fifo.sv
pc_arbiter_rr.sv
regex_cpu_top.sv
tb_regex_asserts.sv
tb_regex_cpu.sv

/* run_sim.sh */
#!/bin/sh
# builds the regex CPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=tb_regex_cpu_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_regex_cpu \
    -f regex_cpu.f \
    -o "$SIM"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1

/* tb_regex_cpu.sv */
`timescale 1ns/100ps

module tb_regex_cpu;
    import regex_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 5;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_ROWS        = 10;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 200 + RESET_CYCLES;
    localparam int MEM_WORDS       = 2 ** MEM_ADDR_WIDTH;
    localparam logic [31:0] SEED   = 32'h3c06_9fd4;

    // one test with its program word, stimulus and the expected outputs of the first PC
    // expected pcs with step set grow by one per further start PC
    typedef struct packed {
        opcode_t             op;
        logic [7:0]          data;
        logic [7:0]          start;
        logic [3:0]          count;
        logic [7:0]          chr;
        logic                rnd_ready;
        logic [1:0]          n_exp;
        logic [7:0]          pc0;
        logic                cur0;
        logic                step0;
        logic [7:0]          pc1;
        logic                cur1;
        logic                step1;
        logic [3:0]          acc;
    } row_t;

    logic                      clk;
    logic                      reset;
    logic [CHAR_WIDTH-1:0]     current_character;
    logic                      input_pc_valid;
    logic [PC_WIDTH-1:0]       input_pc;
    logic                      input_pc_ready;
    logic                      memory_valid;
    logic [MEM_ADDR_WIDTH-1:0] memory_addr;
    logic                      memory_ready;
    logic [MEM_WIDTH-1:0]      memory_data;
    logic                      output_pc_valid;
    logic [PC_WIDTH-1:0]       output_pc;
    logic                      output_pc_is_directed_to_current;
    logic                      output_pc_ready;
    logic                      accepts;
    logic                      running;

    logic [MEM_WIDTH-1:0] prog_mem [MEM_WORDS];
    row_t                 rows [NUM_ROWS];
    logic [31:0]          lcg_state;
    int                   pass_count;
    int                   fail_count;
    int                   row_errors;

    regex_cpu_top dut_i (.*);

    bind regex_cpu_top tb_regex_asserts asserts_i (
        .clk                              (clk),
        .reset                            (reset),
        .memory_valid                     (memory_valid),
        .memory_addr                      (memory_addr),
        .memory_ready                     (memory_ready),
        .output_pc_valid                  (output_pc_valid),
        .output_pc                        (output_pc),
        .output_pc_is_directed_to_current (output_pc_is_directed_to_current),
        .output_pc_ready                  (output_pc_ready),
        .running                          (running)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_bit(output logic b);
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[31];
    endtask

    // unused words decode as END_WITHOUT_ACCEPTING, tagged with their address
    function automatic logic [MEM_WIDTH-1:0] fill_word(input logic [MEM_ADDR_WIDTH-1:0] a);
        logic [OPCODE_WIDTH-1:0] code;
        code = END_WITHOUT_ACCEPTING;
        return {2'b00, a[MEM_ADDR_WIDTH-1:PC_WIDTH], code, a[PC_WIDTH-1:0]};
    endfunction

    task automatic load_table();
        // op, data, start, count, chr, rnd, n, pc0, cur0, step0, pc1, cur1, step1, acc
        rows[0] = '{MATCH, 8'h61, 8'h10, 4'd1, 8'h61, 1'b0, 2'd1,
                    8'h11, 1'b0, 1'b1, 8'h00, 1'b0, 1'b0, 4'd0};
        rows[1] = '{MATCH, 8'h61, 8'h10, 4'd1, 8'h62, 1'b0, 2'd0,
                    8'h00, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 4'd0};
        rows[2] = '{MATCH_ANY, 8'h00, 8'h22, 4'd1, 8'h7a, 1'b1, 2'd1,
                    8'h23, 1'b0, 1'b1, 8'h00, 1'b0, 1'b0, 4'd0};
        rows[3] = '{JMP, 8'h05, 8'h30, 4'd1, 8'h41, 1'b0, 2'd1,
                    8'h05, 1'b1, 1'b0, 8'h00, 1'b0, 1'b0, 4'd0};
        rows[4] = '{SPLIT, 8'h50, 8'h34, 4'd1, 8'h41, 1'b0, 2'd2,
                    8'h35, 1'b1, 1'b1, 8'h50, 1'b1, 1'b0, 4'd0};
        rows[5] = '{ACCEPT, 8'h00, 8'h01, 4'd1, 8'h00, 1'b0, 2'd0,
                    8'h00, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 4'd1};
        rows[6] = '{ACCEPT, 8'h00, 8'h01, 4'd1, 8'h41, 1'b0, 2'd0,
                    8'h00, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 4'd0};
        rows[7] = '{ACCEPT_PARTIAL, 8'h00, 8'h02, 4'd1, 8'h41, 1'b0, 2'd0,
                    8'h00, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 4'd1};
        rows[8] = '{END_WITHOUT_ACCEPTING, 8'h00, 8'h03, 4'd1, 8'h00, 1'b0, 2'd0,
                    8'h00, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 4'd0};
        // twelve SPLITs back to back under random back-pressure
        rows[9] = '{SPLIT, 8'h20, 8'h40, 4'd12, 8'h41, 1'b1, 2'd2,
                    8'h41, 1'b1, 1'b1, 8'h20, 1'b1, 1'b0, 4'd0};
    endtask

    task automatic run_row(input int r, output int errors);
        row_t                      row;
        logic [8:0]                expected [$];
        logic [8:0]                got [$];
        logic [PC_WIDTH-1:0]       pc;
        logic [MEM_ADDR_WIDTH-1:0] addr_s;
        logic                      mem_acc;
        logic                      in_acc;
        logic                      done;
        logic                      rb;
        int                        sent;
        int                        acc_cnt;
        int                        found;
        int                        i;
        int                        j;

        row = rows[r];
        errors = 0;
        for (i = 0; i < int'(row.count); i++)
        begin
            pc = row.start + PC_WIDTH'(i);
            prog_mem[MEM_ADDR_WIDTH'(pc)] = {5'b00000, row.op, row.data};
            if (row.n_exp > 2'd0)
                expected.push_back({row.cur0, row.pc0 + (row.step0 ? PC_WIDTH'(i) : 8'h00)});
            if (row.n_exp > 2'd1)
                expected.push_back({row.cur1, row.pc1 + (row.step1 ? PC_WIDTH'(i) : 8'h00)});
        end

        sent = 0;
        acc_cnt = 0;
        done = 1'b0;
        current_character = row.chr;
        input_pc_valid = 1'b1;
        input_pc = row.start;
        draw_bit(rb);
        output_pc_ready = row.rnd_ready ? rb : 1'b1;

        while (!done)
        begin
            // everything settles before the falling edge
            @(negedge clk);
            if (output_pc_valid && output_pc_ready)
                got.push_back({output_pc_is_directed_to_current, output_pc});
            if (accepts)
                acc_cnt++;
            mem_acc = memory_valid && memory_ready;
            addr_s = memory_addr;
            in_acc = input_pc_valid && input_pc_ready;
            if (in_acc)
                sent++;
            done = (sent == int'(row.count)) && !in_acc && !running;

            @(posedge clk);
            #DRIVE_DELAY;
            if (mem_acc)
                memory_data = prog_mem[addr_s];
            draw_bit(memory_ready);
            draw_bit(rb);
            output_pc_ready = row.rnd_ready ? rb : 1'b1;
            input_pc_valid = (sent < int'(row.count));
            input_pc = row.start + PC_WIDTH'(sent);
        end

        // compare as a multiset
        for (i = 0; i < got.size(); i++)
        begin
            found = -1;
            for (j = 0; j < expected.size(); j++)
            begin
                if (found < 0 && expected[j] == got[i])
                    found = j;
            end
            if (found >= 0)
                expected.delete(found);
            else
            begin
                $display("CHECK FAILED output_pc: unexpected 0x%h tag 0x%h",
                         got[i][7:0], got[i][8]);
                errors++;
            end
        end
        for (i = 0; i < expected.size(); i++)
        begin
            $display("CHECK FAILED output_pc: expected 0x%h tag 0x%h, got none",
                     expected[i][7:0], expected[i][8]);
            errors++;
        end
        if (acc_cnt != int'(row.acc))
        begin
            $display("CHECK FAILED accepts: expected 0x%h pulses, got 0x%h", row.acc, acc_cnt);
            errors++;
        end
    endtask

    initial
    begin
        reset = 1'b1;
        current_character = '0;
        input_pc_valid = 1'b0;
        input_pc = '0;
        memory_ready = 1'b0;
        memory_data = '0;
        output_pc_ready = 1'b0;
        lcg_state = SEED;
        pass_count = 0;
        fail_count = 0;
        for (int a = 0; a < MEM_WORDS; a++)
            prog_mem[a] = fill_word(MEM_ADDR_WIDTH'(a));
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            run_row(r, row_errors);
            if (row_errors == 0)
            begin
                pass_count++;
                $display("test %0d %s: passed", r, rows[r].op.name());
            end
            else
            begin
                fail_count++;
                $display("test %0d %s: %0d errors", r, rows[r].op.name(), row_errors);
            end
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* tb_regex_asserts.sv */
`timescale 1ns/100ps

module tb_regex_asserts (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 memory_valid,
    input logic [regex_pkg::MEM_ADDR_WIDTH-1:0] memory_addr,
    input logic                                 memory_ready,
    input logic                                 output_pc_valid,
    input logic [regex_pkg::PC_WIDTH-1:0]       output_pc,
    input logic                                 output_pc_is_directed_to_current,
    input logic                                 output_pc_ready,
    input logic                                 running
);

    // a stalled output keeps its PC and tag
    output_stable: assert property (@(posedge clk) disable iff (reset)
        output_pc_valid && !output_pc_ready |=>
            $stable(output_pc) && $stable(output_pc_is_directed_to_current))
        else $error("output PC or tag changed while the output was stalled");

    // a waiting memory request keeps its address
    memory_addr_stable: assert property (@(posedge clk) disable iff (reset)
        memory_valid && !memory_ready |=> !memory_valid || $stable(memory_addr))
        else $error("memory address changed while the request was waiting");

    // nothing is active right after reset
    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !output_pc_valid && !memory_valid && !running)
        else $error("pipeline active in the cycle after reset");

endmodule

/* regex_cpu_top.sv */
`timescale 1ns/100ps

module regex_cpu_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [regex_pkg::CHAR_WIDTH-1:0]     current_character,
    input  logic                                 input_pc_valid,
    input  logic [regex_pkg::PC_WIDTH-1:0]       input_pc,
    output logic                                 input_pc_ready,
    output logic                                 memory_valid,
    output logic [regex_pkg::MEM_ADDR_WIDTH-1:0] memory_addr,
    input  logic                                 memory_ready,
    input  logic [regex_pkg::MEM_WIDTH-1:0]      memory_data,
    output logic                                 output_pc_valid,
    output logic [regex_pkg::PC_WIDTH-1:0]       output_pc,
    output logic                                 output_pc_is_directed_to_current,
    input  logic                                 output_pc_ready,
    output logic                                 accepts,
    output logic                                 running
);

    logic exec_busy;

    issue_if     issue_bus ();
    // stage outputs into the buffers, and buffers into the merge
    pc_stream_if s1_bus ();
    pc_stream_if s2_bus ();
    pc_stream_if q0_bus ();
    pc_stream_if q1_bus ();

    regex_fetch fetch_i (
        .clk            (clk),
        .reset          (reset),
        .input_pc_valid (input_pc_valid),
        .input_pc       (input_pc),
        .input_pc_ready (input_pc_ready),
        .memory_valid   (memory_valid),
        .memory_addr    (memory_addr),
        .memory_ready   (memory_ready),
        .memory_data    (memory_data),
        .issue          (issue_bus.fetch)
    );

    regex_execute execute_i (
        .clk               (clk),
        .reset             (reset),
        .current_character (current_character),
        .issue             (issue_bus.exec),
        .out1              (s1_bus.source),
        .out2              (s2_bus.source),
        .accepts           (accepts),
        .busy              (exec_busy)
    );

    pc_fifo fifo0 (.clk(clk), .reset(reset), .wr(s1_bus.sink), .rd(q0_bus.source));
    pc_fifo fifo1 (.clk(clk), .reset(reset), .wr(s2_bus.sink), .rd(q1_bus.source));

    pc_arbiter_rr arbiter_i (
        .clk            (clk),
        .reset          (reset),
        .in0            (q0_bus.sink),
        .in1            (q1_bus.sink),
        .out_valid      (output_pc_valid),
        .out_pc         (output_pc),
        .out_to_current (output_pc_is_directed_to_current),
        .out_ready      (output_pc_ready)
    );

    // work is pending anywhere from the fetch slot to the buffers
    assign running = exec_busy || issue_bus.valid || q0_bus.valid || q1_bus.valid;

endmodule

/* pc_arbiter_rr.sv */
`timescale 1ns/100ps

module pc_arbiter_rr (
    input  logic                           clk,
    input  logic                           reset,
    pc_stream_if.sink                      in0,
    pc_stream_if.sink                      in1,
    output logic                           out_valid,
    output logic [regex_pkg::PC_WIDTH-1:0] out_pc,
    output logic                           out_to_current,
    input  logic                           out_ready
);

    // prio low favours in0
    logic prio;
    // grant held while the output waits, so its data stays put
    logic held;
    logic held_sel;
    logic sel;
    logic xfer;

    always_comb
    begin
        if (held)
            sel = held_sel;
        else
            sel = in1.valid && (prio || !in0.valid);
    end

    assign out_valid      = sel ? in1.valid : in0.valid;
    assign out_pc         = sel ? in1.pc : in0.pc;
    assign out_to_current = sel ? in1.to_current : in0.to_current;

    assign in0.ready = !sel && out_ready;
    assign in1.ready = sel && out_ready;
    assign xfer      = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prio     <= 1'b0;
            held     <= 1'b0;
            held_sel <= 1'b0;
        end
        else if (xfer)
        begin
            // favour the other stream next time
            prio <= !sel;
            held <= 1'b0;
        end
        else if (out_valid)
        begin
            held     <= 1'b1;
            held_sel <= sel;
        end
    end

endmodule

/* pc_fifo.sv */
`timescale 1ns/100ps

module pc_fifo (
    input  logic        clk,
    input  logic        reset,
    pc_stream_if.sink   wr,
    pc_stream_if.source rd
);
    import regex_pkg::*;

    localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

    // each entry is {pc, to_current}
    logic [PC_WIDTH:0]          mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   count;
    logic                       do_wr;
    logic                       do_rd;

    assign wr.ready = (count != (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
    assign rd.valid = (count != '0);

    assign do_wr = wr.valid && wr.ready;
    assign do_rd = rd.valid && rd.ready;

    assign rd.pc         = mem[rd_ptr][PC_WIDTH:1];
    assign rd.to_current = mem[rd_ptr][0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            // read and write together leave the occupancy as it is
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= {wr.pc, wr.to_current};
    end

endmodule

/* regex_execute.sv */
`timescale 1ns/100ps

module regex_execute (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [regex_pkg::CHAR_WIDTH-1:0] current_character,
    issue_if.exec                            issue,
    pc_stream_if.source                      out1,
    pc_stream_if.source                      out2,
    output logic                             accepts,
    output logic                             busy
);
    import regex_pkg::*;

    // stage 1 state
    logic                   s1_valid;
    logic [PC_WIDTH-1:0]    s1_pc;
    logic [INSTR_WIDTH-1:0] s1_instr;

    // stage 2 only ever holds the second target of a SPLIT
    logic                   s2_valid;
    logic [DATA_WIDTH-1:0]  s2_target;

    opcode_t                s1_op;
    logic [DATA_WIDTH-1:0]  s1_data;
    logic                   s1_emit;
    logic [PC_WIDTH-1:0]    s1_next_pc;
    logic                   s1_next_cur;
    logic                   s1_split;

    logic                   s2_adv;
    logic                   s2_free;
    logic                   s1_blocked;
    logic                   s1_adv;

    assign s1_op   = opcode_t'(s1_instr[OPCODE_MSB:OPCODE_LSB]);
    assign s1_data = s1_instr[DATA_MSB:DATA_LSB];

    // stage 1 decode
    always_comb
    begin
        s1_emit     = 1'b0;
        s1_next_pc  = s1_pc + PC_WIDTH'(1);
        s1_next_cur = 1'b1;
        s1_split    = 1'b0;
        accepts     = 1'b0;
        if (s1_valid)
        begin
            case (s1_op)
                ACCEPT:
                    accepts = (current_character == '0);
                ACCEPT_PARTIAL:
                    accepts = 1'b1;
                SPLIT:
                begin
                    // pc+1 leaves here, the data target leaves from stage 2
                    s1_emit  = 1'b1;
                    s1_split = 1'b1;
                end
                MATCH:
                begin
                    s1_emit     = (current_character == s1_data);
                    s1_next_cur = 1'b0;
                end
                MATCH_ANY:
                begin
                    s1_emit     = 1'b1;
                    s1_next_cur = 1'b0;
                end
                JMP:
                begin
                    s1_emit    = 1'b1;
                    s1_next_pc = s1_data;
                end
                default:
                begin
                    // END_WITHOUT_ACCEPTING and unused codes retire silently
                end
            endcase
        end
    end

    // stall chain evaluated from the last stage backwards
    assign s2_adv  = s2_valid && out2.ready;
    assign s2_free = !s2_valid || s2_adv;

    // a SPLIT holds its first output back until stage 2 can take the second,
    // otherwise pc+1 would be written again on every stalled cycle
    assign s1_blocked = s1_split && !s2_free;
    assign s1_adv     = s1_valid && !s1_blocked && (!s1_emit || out1.ready);

    assign issue.take = !s1_valid || s1_adv;

    assign out1.valid      = s1_emit && !s1_blocked;
    assign out1.pc         = s1_next_pc;
    assign out1.to_current = s1_next_cur;

    assign out2.valid      = s2_valid;
    assign out2.pc         = s2_target;
    assign out2.to_current = 1'b1;

    assign busy = s1_valid || s2_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else
        begin
            if (issue.take)
                s1_valid <= issue.valid;
            if (s1_adv && s1_split)
                s2_valid <= 1'b1;
            else if (s2_adv)
                s2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue.take && issue.valid)
        begin
            s1_pc    <= issue.pc;
            s1_instr <= issue.instr;
        end
        if (s1_adv && s1_split)
            s2_target <= s1_data;
    end

endmodule

/* regex_fetch.sv */
`timescale 1ns/100ps

module regex_fetch (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 input_pc_valid,
    input  logic [regex_pkg::PC_WIDTH-1:0]       input_pc,
    output logic                                 input_pc_ready,
    output logic                                 memory_valid,
    output logic [regex_pkg::MEM_ADDR_WIDTH-1:0] memory_addr,
    input  logic                                 memory_ready,
    input  logic [regex_pkg::MEM_WIDTH-1:0]      memory_data,
    issue_if.fetch                               issue
);
    import regex_pkg::*;

    logic                   slot_valid;
    logic                   has_to_save;
    logic [PC_WIDTH-1:0]    slot_pc;
    logic [INSTR_WIDTH-1:0] slot_instr;
    logic [INSTR_WIDTH-1:0] instr_next;
    logic                   slot_moves;
    logic                   slot_free;
    logic                   accept;

    // the slot can be refilled when empty or when stage 1 takes it now
    assign slot_moves = slot_valid && issue.take;
    assign slot_free  = !slot_valid || slot_moves;

    assign memory_valid   = input_pc_valid && slot_free;
    assign memory_addr    = {{(MEM_ADDR_WIDTH - PC_WIDTH){1'b0}}, input_pc};
    assign accept         = memory_valid && memory_ready;
    assign input_pc_ready = accept;

    // memory word is only valid in the cycle after acceptance
    assign instr_next = has_to_save ? memory_data[INSTR_WIDTH-1:0] : slot_instr;

    assign issue.valid = slot_valid;
    assign issue.pc    = slot_pc;
    assign issue.instr = instr_next;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            slot_valid  <= 1'b0;
            has_to_save <= 1'b0;
        end
        else
        begin
            has_to_save <= accept;
            if (accept)
                slot_valid <= 1'b1;
            else if (slot_moves)
                slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        slot_instr <= instr_next;
        if (accept)
            slot_pc <= input_pc;
    end

endmodule

/* issue_if.sv */
`timescale 1ns/100ps

// fetched instruction handed from the fetch slot to execute stage 1
interface issue_if;
    import regex_pkg::*;

    logic                   valid;
    logic [PC_WIDTH-1:0]    pc;
    logic [INSTR_WIDTH-1:0] instr;
    // stage 1 will be free at the next edge
    logic                   take;

    modport fetch (
        output valid,
        output pc,
        output instr,
        input  take
    );

    modport exec (
        input  valid,
        input  pc,
        input  instr,
        output take
    );

endinterface

/* pc_stream_if.sv */
`timescale 1ns/100ps

// one stream of continuation PCs with a ready/valid handshake
interface pc_stream_if;
    import regex_pkg::*;

    logic                valid;
    logic                ready;
    logic [PC_WIDTH-1:0] pc;
    // high when the PC belongs to the current character
    logic                to_current;

    modport source (
        output valid,
        output pc,
        output to_current,
        input  ready
    );

    modport sink (
        input  valid,
        input  pc,
        input  to_current,
        output ready
    );

endinterface

/* regex_pkg.sv */
package regex_pkg;

    // datapath widths
    localparam int PC_WIDTH       = 8;
    localparam int CHAR_WIDTH     = 8;
    localparam int MEM_WIDTH      = 16;
    localparam int MEM_ADDR_WIDTH = 11;

    // instruction format taken from the low bits of a memory word
    localparam int OPCODE_WIDTH = 3;
    localparam int DATA_WIDTH   = 8;
    localparam int INSTR_WIDTH  = OPCODE_WIDTH + DATA_WIDTH;

    // field positions inside an instruction
    localparam int OPCODE_MSB = INSTR_WIDTH - 1;
    localparam int OPCODE_LSB = DATA_WIDTH;
    localparam int DATA_MSB   = DATA_WIDTH - 1;
    localparam int DATA_LSB   = 0;

    // each output buffer holds 2**FIFO_DEPTH_LOG2 entries
    localparam int FIFO_DEPTH_LOG2 = 2;

    // bytecode opcodes
    typedef enum logic [OPCODE_WIDTH-1:0] {
        ACCEPT                = 3'd0,
        ACCEPT_PARTIAL        = 3'd1,
        SPLIT                 = 3'd2,
        MATCH                 = 3'd3,
        MATCH_ANY             = 3'd4,
        JMP                   = 3'd5,
        END_WITHOUT_ACCEPTING = 3'd6
    } opcode_t;

endpackage
